/* src/cam_cfg.svh */
`ifndef CAM_CFG_SVH
`define CAM_CFG_SVH

// Bus geometry
`define CAM_ADR_W           9
`define CAM_DAT_W           32

// Capture FIFO
`define CAM_FIFO_DEPTH      512
`define CAM_LVL_W           10
`define CAM_BEATS_PER_WORD  4
`define CAM_ALMOST_FULL     480

// Register map
`define CAM_ADR_ID          9'h000
`define CAM_ADR_REV         9'h001
`define CAM_ADR_GPIO_IN     9'h002
`define CAM_ADR_GPIO_OUT    9'h003
`define CAM_ADR_GPIO_OE     9'h004
`define CAM_ADR_FIFO_DATA   9'h040
`define CAM_ADR_FIFO_FLAGS  9'h041

// Fixed register contents
`define CAM_DEVICE_ID       32'hF1F07E57
`define CAM_REV_NUM         16'h0100
`define CAM_DEF_REG         32'hFABDEFAC
`define CAM_GPIO_RST        8'h00

`endif

/* src/cam_pkg.sv */
`include "cam_cfg.svh"

package cam_pkg;

    // Host request toward the register window
    typedef struct packed {
        logic [`CAM_ADR_W-1:0] adr;
        logic [`CAM_DAT_W-1:0] dat;
        logic [3:0]            byte_stb;
        logic                  we;
        logic                  cyc;
        logic                  stb;
    } wb_req_t;

    typedef struct packed {
        logic [`CAM_DAT_W-1:0] dat;
        logic                  ack;
    } wb_rsp_t;

    // Camera sync levels sampled on PCLKI
    typedef struct packed {
        logic vsync;
        logic href;
    } cam_sync_t;

    typedef struct packed {
        logic [`CAM_LVL_W-1:0] level;
        logic                  empty;
        logic                  almost_full;
        logic                  full;
        logic                  overflow;    // Sticky until reset
    } fifo_stat_t;

endpackage

/* src/cam_pixel_packer.sv */
`timescale 1ns/1ps
`include "cam_cfg.svh"

module cam_pixel_packer
(
    input  logic                  PCLKI,
    input  logic                  WBs_RST_i,
    input  cam_pkg::cam_sync_t    cam_i,
    output logic                  push_o,
    output logic [`CAM_DAT_W-1:0] word_o
);

    localparam int BEAT_W = $clog2(`CAM_BEATS_PER_WORD);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`CAM_BEATS_PER_WORD - 1);

    logic                  beat_vld;
    logic                  group_done;
    logic [BEAT_W-1:0]     beat_cnt;
    logic [`CAM_DAT_W-1:0] word_cnt;    // Free-running group count

    // A beat counts only inside an active line of an active frame
    assign beat_vld   = cam_i.href & cam_i.vsync;
    assign group_done = beat_vld && (beat_cnt == LAST_BEAT);

    // ------------------------------------------------------------------------
    // Beat and group counters
    // ------------------------------------------------------------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            beat_cnt <= '0;
            word_cnt <= '0;
            push_o   <= 1'b0;
        end
        else
        begin
            push_o <= group_done;           // One-cycle pulse per group
            if (beat_vld)
                beat_cnt <= beat_cnt + 1'b1; // Wraps after the last beat
            if (group_done)
                word_cnt <= word_cnt + 1'b1;
        end
    end

    // Word n carries the value n
    always_ff @(posedge PCLKI)
    begin
        if (group_done)
            word_o <= word_cnt;
    end

endmodule

/* src/cam_word_fifo.sv */
`timescale 1ns/1ps
`include "cam_cfg.svh"

module cam_word_fifo
(
    input  logic                  PCLKI,
    input  logic                  WBs_RST_i,
    input  logic                  push_i,
    input  logic [`CAM_DAT_W-1:0] word_i,
    input  logic                  pop_i,
    output logic [`CAM_DAT_W-1:0] head_o,
    output cam_pkg::fifo_stat_t   stat_o
);

    localparam int PTR_W = $clog2(`CAM_FIFO_DEPTH);
    localparam logic [`CAM_LVL_W-1:0] FULL_LVL = `CAM_LVL_W'(`CAM_FIFO_DEPTH);
    localparam logic [`CAM_LVL_W-1:0] AF_LVL   = `CAM_LVL_W'(`CAM_ALMOST_FULL);

    logic [`CAM_DAT_W-1:0] mem [`CAM_FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [`CAM_LVL_W-1:0] level;
    logic                  overflow;
    logic                  empty;
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    assign empty   = (level == '0);
    assign full    = (level == FULL_LVL);
    assign do_push = push_i & ~full;    // Dropped when full
    assign do_pop  = pop_i & ~empty;

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    always_ff @(posedge PCLKI)
    begin
        if (do_push)
            mem[wr_ptr] <= word_i;
    end

    // Show-ahead head word
    assign head_o = empty ? '0 : mem[rd_ptr];

    // ------------------------------------------------------------------------
    // Pointers, level and overflow
    // ------------------------------------------------------------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;    // Depth is a power of two
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                level <= level + 1'b1;
            else if (do_pop && !do_push)
                level <= level - 1'b1;
            if (push_i && full)
                overflow <= 1'b1;
        end
    end

    assign stat_o.level       = level;
    assign stat_o.empty       = empty;
    assign stat_o.almost_full = (level >= AF_LVL);
    assign stat_o.full        = full;
    assign stat_o.overflow    = overflow;

endmodule

/* src/cam_regs.sv */
`timescale 1ns/1ps
`include "cam_cfg.svh"

module cam_regs
(
    input  logic                  PCLKI,
    input  logic                  WBs_RST_i,
    input  cam_pkg::wb_req_t      wbs_req_i,
    output cam_pkg::wb_rsp_t      wbs_rsp_o,
    input  logic [7:0]            gpio_i,
    output logic [7:0]            gpio_out_o,
    output logic [7:0]            gpio_oe_o,
    input  logic [`CAM_DAT_W-1:0] head_i,
    input  cam_pkg::fifo_stat_t   stat_i,
    output logic                  pop_o
);

    logic                  ack;
    logic                  ack_nxt;
    logic                  wr_en;
    logic                  rd_en;
    logic [`CAM_DAT_W-1:0] rd_mux;
    logic [`CAM_DAT_W-1:0] rd_dat;
    logic [`CAM_DAT_W-1:0] flags;

    // ------------------------------------------------------------------------
    // Handshake and decode
    // ------------------------------------------------------------------------
    // ack is forced low for a cycle after each transfer
    assign ack_nxt = wbs_req_i.cyc & wbs_req_i.stb & ~ack;
    assign wr_en   = ack_nxt & wbs_req_i.we;
    assign rd_en   = ack_nxt & ~wbs_req_i.we;

    // Pop and head capture share the edge that raises ack
    assign pop_o = rd_en && (wbs_req_i.adr == `CAM_ADR_FIFO_DATA);

    always_ff @(posedge PCLKI or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            ack        <= 1'b0;
            gpio_out_o <= `CAM_GPIO_RST;
            gpio_oe_o  <= `CAM_GPIO_RST;
        end
        else
        begin
            ack <= ack_nxt;
            if (wr_en && wbs_req_i.byte_stb[0])
            begin
                if (wbs_req_i.adr == `CAM_ADR_GPIO_OUT)
                    gpio_out_o <= wbs_req_i.dat[7:0];
                if (wbs_req_i.adr == `CAM_ADR_GPIO_OE)
                    gpio_oe_o <= wbs_req_i.dat[7:0];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------
    assign flags = {12'h000,
                    stat_i.overflow,        // Bit 19
                    stat_i.full,            // Bit 18
                    stat_i.almost_full,     // Bit 17
                    stat_i.empty,           // Bit 16
                    6'h00,
                    stat_i.level};

    always_comb
    begin
        case (wbs_req_i.adr)
            `CAM_ADR_ID:         rd_mux = `CAM_DEVICE_ID;
            `CAM_ADR_REV:        rd_mux = {16'h0000, `CAM_REV_NUM};
            `CAM_ADR_GPIO_IN:    rd_mux = {24'h000000, gpio_i};
            `CAM_ADR_GPIO_OUT:   rd_mux = {24'h000000, gpio_out_o};
            `CAM_ADR_GPIO_OE:    rd_mux = {24'h000000, gpio_oe_o};
            `CAM_ADR_FIFO_DATA:  rd_mux = head_i;
            `CAM_ADR_FIFO_FLAGS: rd_mux = flags;
            default:             rd_mux = `CAM_DEF_REG;
        endcase
    end

    // Held until the next read
    always_ff @(posedge PCLKI)
    begin
        if (rd_en)
            rd_dat <= rd_mux;
    end

    assign wbs_rsp_o.dat = rd_dat;
    assign wbs_rsp_o.ack = ack;

endmodule

/* src/cam_top.sv */
`timescale 1ns/1ps
`include "cam_cfg.svh"

module cam_top
(
    input  logic               PCLKI,
    input  logic               WBs_RST_i,
    input  cam_pkg::wb_req_t   wbs_req_i,
    output cam_pkg::wb_rsp_t   wbs_rsp_o,
    input  cam_pkg::cam_sync_t cam_i,
    input  logic [7:0]         gpio_i,
    output logic [7:0]         gpio_out_o,
    output logic [7:0]         gpio_oe_o
);

    import cam_pkg::*;

    logic                  push;
    logic                  pop;
    logic [`CAM_DAT_W-1:0] word;
    logic [`CAM_DAT_W-1:0] head;
    fifo_stat_t            stat;

    // ------------------------------------------------------------------------
    // Capture path
    // ------------------------------------------------------------------------
    cam_pixel_packer u_packer (
        .PCLKI     (PCLKI),
        .WBs_RST_i (WBs_RST_i),
        .cam_i     (cam_i),
        .push_o    (push),
        .word_o    (word)
    );

    cam_word_fifo u_fifo (
        .PCLKI     (PCLKI),
        .WBs_RST_i (WBs_RST_i),
        .push_i    (push),
        .word_i    (word),
        .pop_i     (pop),          // From the data-register read
        .head_o    (head),
        .stat_o    (stat)
    );

    // Host register window
    cam_regs u_regs (
        .PCLKI      (PCLKI),
        .WBs_RST_i  (WBs_RST_i),
        .wbs_req_i  (wbs_req_i),
        .wbs_rsp_o  (wbs_rsp_o),
        .gpio_i     (gpio_i),
        .gpio_out_o (gpio_out_o),
        .gpio_oe_o  (gpio_oe_o),
        .head_i     (head),
        .stat_i     (stat),
        .pop_o      (pop)
    );

endmodule

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen
(
    output logic pclk_o,
    output logic rst_o
);

    initial
    begin
        pclk_o = 1'b0;
        forever #4 pclk_o = ~pclk_o;    // 8 ns period
    end

    // Reset spans four rising edges
    initial
    begin
        rst_o = 1'b1;
        repeat (4) @(posedge pclk_o);
        #1 rst_o = 1'b0;
    end

endmodule

/* testbench/cam_top_props.sv */
`timescale 1ns/1ps
`include "cam_cfg.svh"

module cam_top_props
(
    input logic                PCLKI,
    input logic                WBs_RST_i,
    input cam_pkg::wb_req_t    wbs_req_i,
    input cam_pkg::wb_rsp_t    wbs_rsp_i,
    input cam_pkg::fifo_stat_t stat_i,
    input logic                pop_i
);

    // Single-cycle acknowledge
    ack_one_cycle: assert property (@(posedge PCLKI) disable iff (WBs_RST_i)
        wbs_rsp_i.ack |=> !wbs_rsp_i.ack)
        else $error("ack held high for two cycles");

    ack_after_req: assert property (@(posedge PCLKI) disable iff (WBs_RST_i)
        wbs_rsp_i.ack |-> $past(wbs_req_i.cyc && wbs_req_i.stb))
        else $error("ack without a preceding cyc and stb");

    level_bound: assert property (@(posedge PCLKI) disable iff (WBs_RST_i)
        stat_i.level <= `CAM_LVL_W'(`CAM_FIFO_DEPTH))
        else $error("FIFO level above depth");

    // Pop only on the edge that raises ack
    pop_with_ack: assert property (@(posedge PCLKI) disable iff (WBs_RST_i)
        pop_i |=> wbs_rsp_i.ack)
        else $error("FIFO pop without a rising ack");

endmodule

bind cam_top cam_top_props u_props (
    .PCLKI     (PCLKI),
    .WBs_RST_i (WBs_RST_i),
    .wbs_req_i (wbs_req_i),
    .wbs_rsp_i (wbs_rsp_o),
    .stat_i    (stat),
    .pop_i     (pop)
);

/* testbench/tb_cam_top.sv */
`timescale 1ns/1ps
`include "cam_cfg.svh"

module tb_cam_top;

    import cam_pkg::*;

    logic        PCLKI;
    logic        WBs_RST_i;
    wb_req_t     wbs_req;
    wb_rsp_t     wbs_rsp;
    cam_sync_t   cam;
    logic [7:0]  gpio_in;
    logic [7:0]  gpio_out;
    logic [7:0]  gpio_oe;

    logic [7:0]  mdl_gpio_out;          // Register model
    logic [7:0]  mdl_gpio_oe;
    logic [31:0] mdl_q[$];              // Words expected in the FIFO
    logic        mdl_ovf;
    int unsigned beats_driven;
    int unsigned groups_done;
    logic [31:0] got_q[$];
    logic [31:0] exp_q[$];
    string       what_q[$];
    int          fail_cnt;

    tb_clk_gen u_clk (.pclk_o(PCLKI), .rst_o(WBs_RST_i));

    cam_top UUT (
        .PCLKI      (PCLKI),
        .WBs_RST_i  (WBs_RST_i),
        .wbs_req_i  (wbs_req),
        .wbs_rsp_o  (wbs_rsp),
        .cam_i      (cam),
        .gpio_i     (gpio_in),
        .gpio_out_o (gpio_out),
        .gpio_oe_o  (gpio_oe)
    );

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] expected_read(input logic [`CAM_ADR_W-1:0] adr);
        int unsigned lvl;
        logic [31:0] flags;
        logic [31:0] val;
        lvl       = mdl_q.size();
        flags     = '0;
        flags[9:0] = lvl[9:0];
        flags[16] = (lvl == 0);
        flags[17] = (lvl >= `CAM_ALMOST_FULL);
        flags[18] = (lvl == `CAM_FIFO_DEPTH);
        flags[19] = mdl_ovf;
        case (adr)
            `CAM_ADR_ID:         val = `CAM_DEVICE_ID;
            `CAM_ADR_REV:        val = {16'h0000, `CAM_REV_NUM};
            `CAM_ADR_GPIO_IN:    val = {24'h000000, gpio_in};
            `CAM_ADR_GPIO_OUT:   val = {24'h000000, mdl_gpio_out};
            `CAM_ADR_GPIO_OE:    val = {24'h000000, mdl_gpio_oe};
            `CAM_ADR_FIFO_DATA:  val = (lvl > 0) ? mdl_q[0] : 32'h0;  // Head before the pop
            `CAM_ADR_FIFO_FLAGS: val = flags;
            default:             val = `CAM_DEF_REG;
        endcase
        return val;
    endfunction

    // Every fourth qualified beat yields the next group count
    task automatic count_beat();
        beats_driven++;
        if (beats_driven % `CAM_BEATS_PER_WORD == 0)
        begin
            if (mdl_q.size() < `CAM_FIFO_DEPTH)
                mdl_q.push_back(groups_done);
            else
                mdl_ovf = 1'b1;             // Word dropped but the count still advances
            groups_done++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------------
    task automatic end_with_failure();
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            fail_cnt++;
            $display("FAIL %0t ns: %s, got %08h expected %08h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic expect_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        what_q.push_back(what);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    always @(posedge PCLKI)
    begin
        while (got_q.size() > 0)
            check_eq(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic wait_ack(input string what);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge PCLKI);
            cycles++;
            if (cycles > 20 && !wbs_rsp.ack)
            begin
                $display("No bus acknowledge within 20 cycles during %s", what);
                end_with_failure();
            end
        end
        while (!wbs_rsp.ack);
    endtask

    task automatic bus_write(input logic [8:0] adr, input logic [31:0] dat, input logic [3:0] sel);
        @(posedge PCLKI);
        #1;
        wbs_req = '{adr: adr, dat: dat, byte_stb: sel, we: 1'b1, cyc: 1'b1, stb: 1'b1};
        wait_ack("register write");
        if (sel[0] && adr == `CAM_ADR_GPIO_OUT)
            mdl_gpio_out = dat[7:0];
        if (sel[0] && adr == `CAM_ADR_GPIO_OE)
            mdl_gpio_oe = dat[7:0];
        @(posedge PCLKI);
        #1 wbs_req = '0;
    endtask

    task automatic bus_read(input logic [8:0] adr, input string what);
        logic [31:0] exp;
        exp = expected_read(adr);
        @(posedge PCLKI);
        #1;
        wbs_req = '{adr: adr, dat: 32'h0, byte_stb: 4'hF, we: 1'b0, cyc: 1'b1, stb: 1'b1};
        wait_ack(what);
        expect_value(what, wbs_rsp.dat, exp);
        if (adr == `CAM_ADR_FIFO_DATA && mdl_q.size() > 0)
            void'(mdl_q.pop_front());
        @(posedge PCLKI);
        #1 wbs_req = '0;
    endtask

    // Qualified beats separated by random unqualified cycles
    task automatic drive_beats(input int unsigned n_beats, input int unsigned max_gap);
        int unsigned gap;
        int unsigned r;
        for (int unsigned i = 0; i < n_beats; i++)
        begin
            gap = $urandom % (max_gap + 1);
            repeat (gap)
            begin
                @(posedge PCLKI);
                r = $urandom % 3;
                #1 cam = '{vsync: (r == 2), href: (r == 1)};
            end
            @(posedge PCLKI);
            #1 cam = '{vsync: 1'b1, href: 1'b1};
            count_beat();
        end
        @(posedge PCLKI);
        #1 cam = '0;
        repeat (2) @(posedge PCLKI);    // Push plus level update
    endtask

    initial
    begin
        int unsigned n_words;
        int cycles;
        void'($urandom(44638));
        wbs_req      = '0;
        cam          = '0;
        gpio_in      = '0;
        mdl_gpio_out = `CAM_GPIO_RST;
        mdl_gpio_oe  = `CAM_GPIO_RST;
        mdl_ovf      = 1'b0;
        beats_driven = 0;
        groups_done  = 0;
        fail_cnt     = 0;
        cycles       = 0;
        while (WBs_RST_i !== 1'b0)
        begin
            @(posedge PCLKI);
            cycles++;
            if (cycles == 50)
            begin
                $display("Reset was never released");
                end_with_failure();
            end
        end

        // Fixed values after reset
        bus_read(`CAM_ADR_ID, "device ID");
        bus_read(`CAM_ADR_REV, "revision");
        bus_read(9'h1A5, "unmapped address");
        expect_value("gpio_out_o after reset", {24'h0, gpio_out}, {24'h0, mdl_gpio_out});
        expect_value("gpio_oe_o after reset", {24'h0, gpio_oe}, {24'h0, mdl_gpio_oe});
        bus_read(`CAM_ADR_FIFO_FLAGS, "flags after reset");

        // GPIO registers and ports
        repeat (6)
        begin
            bus_write(`CAM_ADR_GPIO_OUT, $urandom, 4'hF);
            bus_read(`CAM_ADR_GPIO_OUT, "GPIO out readback");
            expect_value("gpio_out_o port", {24'h0, gpio_out}, {24'h0, mdl_gpio_out});
            bus_write(`CAM_ADR_GPIO_OE, $urandom, 4'hF);
            bus_read(`CAM_ADR_GPIO_OE, "GPIO OE readback");
            expect_value("gpio_oe_o port", {24'h0, gpio_oe}, {24'h0, mdl_gpio_oe});
        end
        bus_write(`CAM_ADR_GPIO_OUT, ~{24'h0, mdl_gpio_out}, 4'b1110);  // Byte 0 masked
        bus_read(`CAM_ADR_GPIO_OUT, "GPIO out after masked write");
        expect_value("gpio_out_o masked", {24'h0, gpio_out}, {24'h0, mdl_gpio_out});
        bus_write(`CAM_ADR_GPIO_OE, ~{24'h0, mdl_gpio_oe}, 4'b1110);
        bus_read(`CAM_ADR_GPIO_OE, "GPIO OE after masked write");
        expect_value("gpio_oe_o masked", {24'h0, gpio_oe}, {24'h0, mdl_gpio_oe});
        @(posedge PCLKI);
        #1 gpio_in = 8'($urandom);
        bus_read(`CAM_ADR_GPIO_IN, "GPIO in");

        // Capture stream
        n_words = 5 + $urandom % 12;
        drive_beats(4 * n_words, 3);
        bus_read(`CAM_ADR_FIFO_FLAGS, "flags after capture");
        repeat (n_words) bus_read(`CAM_ADR_FIFO_DATA, "captured word");

        // Empty FIFO read
        bus_read(`CAM_ADR_FIFO_DATA, "data read on empty FIFO");
        bus_read(`CAM_ADR_FIFO_FLAGS, "flags after empty read");

        // Overflow and drain
        drive_beats(4 * 530, 0);
        bus_read(`CAM_ADR_FIFO_FLAGS, "flags when full");
        repeat (`CAM_FIFO_DEPTH) bus_read(`CAM_ADR_FIFO_DATA, "drained word");
        bus_read(`CAM_ADR_FIFO_FLAGS, "flags after drain");

        cycles = 0;
        while (got_q.size() > 0)
        begin
            @(posedge PCLKI);
            cycles++;
            if (cycles == 10)
            begin
                $display("Comparison queue did not drain");
                end_with_failure();
            end
        end
        @(negedge PCLKI);
        if (fail_cnt == 0)
        begin
            $display("All tests passed");
            $finish;
        end
        else
            end_with_failure();
    end

endmodule

/* list.f */
+incdir+src
src/cam_pkg.sv
src/cam_pixel_packer.sv
src/cam_word_fifo.sv
src/cam_regs.sv
src/cam_top.sv
testbench/tb_clk_gen.sv
testbench/cam_top_props.sv
testbench/tb_cam_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cam_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv src/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
